/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_secv
FILELIST  = secv.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(BUILD)

/* secv.f */
+incdir+.
secv_pkg.sv
secv_alu.sv
secv_lsu.sv
secv_gpr.sv
secv_decoder.sv
secv_ctrl.sv
secv.sv
tb_secv.sv

/* secv.sv */
// SEC-V processor top
`timescale 1ns/1ps

module secv (
    input  logic              clk_i,
    input  logic              rst_i,

    // Instruction bus
    output logic              imem_cyc_o,
    output logic              imem_stb_o,
    output secv_pkg::sel_t    imem_sel_o,
    output secv_pkg::iadr_t   imem_adr_o,
    input  secv_pkg::inst_t   imem_dat_i,
    input  logic              imem_ack_i,

    // Data bus
    output logic              dmem_cyc_o,
    output logic              dmem_stb_o,
    output logic              dmem_we_o,
    output secv_pkg::sel_t    dmem_sel_o,
    output secv_pkg::dadr_t   dmem_adr_o,
    output secv_pkg::word_t   dmem_dat_o,
    input  secv_pkg::word_t   dmem_dat_i,
    input  logic              dmem_ack_i
);
    import secv_pkg::*;

    // Decoded instruction fields
    inst_t     inst;
    reg_adr_t  rs1_adr;
    reg_adr_t  rs2_adr;
    reg_adr_t  rd_adr;
    funct3_t   funct3;
    word_t     imm;
    funit_t    funit;
    alu_op_t   alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    rd_sel_t   rd_sel;
    pc_sel_t   pc_sel;
    logic      mem_we;

    // Register file and operands
    word_t rs1_dat;
    word_t rs2_dat;
    word_t rd_dat;
    logic  rd_wb;
    word_t src1;
    word_t src2;

    // Unit results
    word_t alu_res;
    logic  take;
    logic  mem_ena;
    logic  mem_rdy;
    word_t mem_dat;

    secv_ctrl u_ctrl (
        .clk_i      (clk_i),      .rst_i      (rst_i),
        .imem_cyc_o (imem_cyc_o), .imem_stb_o (imem_stb_o),
        .imem_sel_o (imem_sel_o), .imem_adr_o (imem_adr_o),
        .imem_dat_i (imem_dat_i), .imem_ack_i (imem_ack_i),
        .inst_o     (inst),       .funit_i    (funit),
        .src1_sel_i (src1_sel),   .src2_sel_i (src2_sel),
        .rd_sel_i   (rd_sel),     .pc_sel_i   (pc_sel),
        .imm_i      (imm),        .rs1_dat_i  (rs1_dat),
        .rs2_dat_i  (rs2_dat),    .src1_o     (src1),
        .src2_o     (src2),       .alu_res_i  (alu_res),
        .take_i     (take),       .mem_ena_o  (mem_ena),
        .mem_rdy_i  (mem_rdy),    .mem_dat_i  (mem_dat),
        .rd_dat_o   (rd_dat),     .rd_wb_o    (rd_wb)
    );

    secv_decoder u_decoder (
        .inst_i     (inst),       .rs1_adr_o  (rs1_adr),
        .rs2_adr_o  (rs2_adr),    .rd_adr_o   (rd_adr),
        .funct3_o   (funct3),     .imm_o      (imm),
        .funit_o    (funit),      .alu_op_o   (alu_op),
        .src1_sel_o (src1_sel),   .src2_sel_o (src2_sel),
        .rd_sel_o   (rd_sel),     .pc_sel_o   (pc_sel),
        .mem_we_o   (mem_we)
    );

    secv_gpr u_gpr (
        .clk_i      (clk_i),      .rst_i      (rst_i),
        .rs1_adr_i  (rs1_adr),    .rs2_adr_i  (rs2_adr),
        .rd_adr_i   (rd_adr),     .rs1_dat_o  (rs1_dat),
        .rs2_dat_o  (rs2_dat),    .rd_dat_i   (rd_dat),
        .rd_wb_i    (rd_wb)
    );

    secv_alu u_alu (
        .op_i       (alu_op),     .src1_i     (src1),
        .src2_i     (src2),       .funct3_i   (funct3),
        .rs1_i      (rs1_dat),    .rs2_i      (rs2_dat),
        .res_o      (alu_res),    .take_o     (take)
    );

    // Address always comes from the ALU adder
    secv_lsu u_lsu (
        .clk_i      (clk_i),      .rst_i      (rst_i),
        .ena_i      (mem_ena),    .we_i       (mem_we),
        .adr_i      (alu_res),    .wdat_i     (rs2_dat),
        .rdat_o     (mem_dat),    .rdy_o      (mem_rdy),
        .dmem_cyc_o (dmem_cyc_o), .dmem_stb_o (dmem_stb_o),
        .dmem_we_o  (dmem_we_o),  .dmem_sel_o (dmem_sel_o),
        .dmem_adr_o (dmem_adr_o), .dmem_dat_o (dmem_dat_o),
        .dmem_dat_i (dmem_dat_i), .dmem_ack_i (dmem_ack_i)
    );

endmodule

/* secv_alu.sv */
// SEC-V ALU and branch compare
`timescale 1ns/1ps

module secv_alu (
    input  secv_pkg::alu_op_t op_i,
    input  secv_pkg::word_t   src1_i,
    input  secv_pkg::word_t   src2_i,
    input  secv_pkg::funct3_t funct3_i,
    input  secv_pkg::word_t   rs1_i,
    input  secv_pkg::word_t   rs2_i,
    output secv_pkg::word_t   res_o,
    output logic              take_o
);
    import secv_pkg::*;

    // Result also serves as jump and branch target
    always_comb begin
        unique case (op_i)
            ALU_ADD:  res_o = src1_i + src2_i;
            ALU_SUB:  res_o = src1_i - src2_i;
            ALU_SLL:  res_o = src1_i << src2_i[4:0];
            ALU_SLT:  res_o = word_t'($signed(src1_i) < $signed(src2_i));
            ALU_SLTU: res_o = word_t'(src1_i < src2_i);
            ALU_XOR:  res_o = src1_i ^ src2_i;
            ALU_SRL:  res_o = src1_i >> src2_i[4:0];
            ALU_SRA:  res_o = word_t'($signed(src1_i) >>> src2_i[4:0]);
            ALU_OR:   res_o = src1_i | src2_i;
            ALU_AND:  res_o = src1_i & src2_i;
            default:  res_o = '0;
        endcase
    end

    // Branch condition on the raw register values
    always_comb begin
        unique case (funct3_i)
            3'b000:  take_o = (rs1_i == rs2_i);
            3'b001:  take_o = (rs1_i != rs2_i);
            3'b100:  take_o = ($signed(rs1_i) < $signed(rs2_i));
            3'b101:  take_o = ($signed(rs1_i) >= $signed(rs2_i));
            3'b110:  take_o = (rs1_i < rs2_i);
            3'b111:  take_o = (rs1_i >= rs2_i);
            default: take_o = 1'b0;
        endcase
    end

endmodule

/* secv_ctrl.sv */
// SEC-V main control
`timescale 1ns/1ps

module secv_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,
    output logic                imem_cyc_o,
    output logic                imem_stb_o,
    output secv_pkg::sel_t      imem_sel_o,
    output secv_pkg::iadr_t     imem_adr_o,
    input  secv_pkg::inst_t     imem_dat_i,
    input  logic                imem_ack_i,
    output secv_pkg::inst_t     inst_o,
    input  secv_pkg::funit_t    funit_i,
    input  secv_pkg::src1_sel_t src1_sel_i,
    input  secv_pkg::src2_sel_t src2_sel_i,
    input  secv_pkg::rd_sel_t   rd_sel_i,
    input  secv_pkg::pc_sel_t   pc_sel_i,
    input  secv_pkg::word_t     imm_i,
    input  secv_pkg::word_t     rs1_dat_i,
    input  secv_pkg::word_t     rs2_dat_i,
    output secv_pkg::word_t     src1_o,
    output secv_pkg::word_t     src2_o,
    input  secv_pkg::word_t     alu_res_i,
    input  logic                take_i,
    output logic                mem_ena_o,
    input  logic                mem_rdy_i,
    input  secv_pkg::word_t     mem_dat_i,
    output secv_pkg::word_t     rd_dat_o,
    output logic                rd_wb_o
);
    import secv_pkg::*;

    state_t state, state_nxt;
    word_t  pc, pc_nxt, pc_inc;
    inst_t  ir;

    assign pc_inc = pc + 32'd4;
    assign inst_o = ir;

    // Instruction fetch request held until ack
    assign imem_cyc_o = (state == STATE_FETCH);
    assign imem_stb_o = (state == STATE_FETCH);
    assign imem_sel_o = '1;
    assign imem_adr_o = pc[IADR_WIDTH-1:0];

    // Memory unit only runs during execute
    assign mem_ena_o = (state == STATE_EXECUTE) && (funit_i == FUNIT_MEM);

    always_comb begin
        unique case (src1_sel_i)
            SRC1_SEL_RS1: src1_o = rs1_dat_i;
            SRC1_SEL_PC:  src1_o = pc;
            default:      src1_o = '0;
        endcase
        unique case (src2_sel_i)
            SRC2_SEL_RS2: src2_o = rs2_dat_i;
            SRC2_SEL_IMM: src2_o = imm_i;
            default:      src2_o = '0;
        endcase
    end

    // Loads write back the bus word
    always_comb begin
        unique case (rd_sel_i)
            RD_SEL_FUNIT: rd_dat_o = (funit_i == FUNIT_MEM) ? mem_dat_i : alu_res_i;
            RD_SEL_IMM:   rd_dat_o = imm_i;
            RD_SEL_NXTPC: rd_dat_o = pc_inc;
            default:      rd_dat_o = '0;
        endcase
    end
    assign rd_wb_o = (state == STATE_WB) && (rd_sel_i != RD_SEL_NONE);

    // Next PC with bit 0 of the jump target cleared
    always_comb begin
        unique case (pc_sel_i)
            PC_SEL_FUNIT:  pc_nxt = {alu_res_i[XLEN-1:1], 1'b0};
            PC_SEL_BRANCH: pc_nxt = take_i ? alu_res_i : pc_inc;
            default:       pc_nxt = pc_inc;
        endcase
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            STATE_IDLE:    state_nxt = STATE_FETCH;
            STATE_FETCH:   if (imem_ack_i) state_nxt = STATE_DECODE;
            STATE_DECODE:  state_nxt = STATE_EXECUTE;
            // Wait for the LSU only on memory ops
            STATE_EXECUTE: if (funit_i != FUNIT_MEM || mem_rdy_i) state_nxt = STATE_WB;
            STATE_WB:      state_nxt = STATE_FETCH;
            default:       state_nxt = STATE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= STATE_IDLE;
            pc    <= '0;
            ir    <= INST_NOP;
        end else begin
            state <= state_nxt;
            if (state == STATE_FETCH && imem_ack_i) begin
                ir <= imem_dat_i;
            end
            if (state == STATE_WB) begin
                pc <= pc_nxt;
            end
        end
    end

    // Fetch request and address held until ack
    a_fetch_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        (imem_stb_o && !imem_ack_i) |=> (imem_stb_o && $stable(imem_adr_o)));

    // Targets from decoder and ALU keep the PC word aligned
    a_pc_align: assert property (@(posedge clk_i) disable iff (rst_i) pc[1:0] == 2'b00);

endmodule

/* secv_decoder.sv */
// SEC-V instruction decoder
`timescale 1ns/1ps

module secv_decoder (
    input  secv_pkg::inst_t     inst_i,
    output secv_pkg::reg_adr_t  rs1_adr_o,
    output secv_pkg::reg_adr_t  rs2_adr_o,
    output secv_pkg::reg_adr_t  rd_adr_o,
    output secv_pkg::funct3_t   funct3_o,
    output secv_pkg::word_t     imm_o,
    output secv_pkg::funit_t    funit_o,
    output secv_pkg::alu_op_t   alu_op_o,
    output secv_pkg::src1_sel_t src1_sel_o,
    output secv_pkg::src2_sel_t src2_sel_o,
    output secv_pkg::rd_sel_t   rd_sel_o,
    output secv_pkg::pc_sel_t   pc_sel_o,
    output logic                mem_we_o
);
    import secv_pkg::*;

    logic [6:0] opcode;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t    arith_op;

    assign opcode    = inst_i[6:0];
    assign rs1_adr_o = inst_i[19:15];
    assign rs2_adr_o = inst_i[24:20];
    assign rd_adr_o  = inst_i[11:7];
    assign funct3_o  = inst_i[14:12];

    // Immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // SUB only exists for OP
    always_comb begin
        unique case (inst_i[14:12])
            3'b000:  arith_op = (opcode == OPC_OP && inst_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = inst_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // Unknown opcodes fall through as a NOP
        imm_o      = '0;
        funit_o    = FUNIT_NONE;
        alu_op_o   = ALU_ADD;
        src1_sel_o = SRC1_SEL_ZERO;
        src2_sel_o = SRC2_SEL_ZERO;
        rd_sel_o   = RD_SEL_NONE;
        pc_sel_o   = PC_SEL_NXTPC;
        mem_we_o   = 1'b0;
        unique case (opcode)
            OPC_LUI: begin
                imm_o    = imm_u;
                rd_sel_o = RD_SEL_IMM;
            end
            OPC_AUIPC: begin
                imm_o      = imm_u;
                funit_o    = FUNIT_ALU;
                src1_sel_o = SRC1_SEL_PC;
                src2_sel_o = SRC2_SEL_IMM;
                rd_sel_o   = RD_SEL_FUNIT;
            end
            OPC_JAL, OPC_JALR: begin
                // Link is PC + 4 and the target comes from the adder
                imm_o      = (opcode == OPC_JAL) ? imm_j : imm_i;
                funit_o    = FUNIT_ALU;
                src1_sel_o = (opcode == OPC_JAL) ? SRC1_SEL_PC : SRC1_SEL_RS1;
                src2_sel_o = SRC2_SEL_IMM;
                rd_sel_o   = RD_SEL_NXTPC;
                pc_sel_o   = PC_SEL_FUNIT;
            end
            OPC_BRANCH: begin
                imm_o      = imm_b;
                funit_o    = FUNIT_ALU;
                src1_sel_o = SRC1_SEL_PC;
                src2_sel_o = SRC2_SEL_IMM;
                pc_sel_o   = PC_SEL_BRANCH;
            end
            OPC_LOAD, OPC_STORE: begin
                imm_o      = (opcode == OPC_STORE) ? imm_s : imm_i;
                funit_o    = FUNIT_MEM;
                src1_sel_o = SRC1_SEL_RS1;
                src2_sel_o = SRC2_SEL_IMM;
                rd_sel_o   = (opcode == OPC_LOAD) ? RD_SEL_FUNIT : RD_SEL_NONE;
                mem_we_o   = (opcode == OPC_STORE);
            end
            OPC_OPIMM, OPC_OP: begin
                imm_o      = imm_i;
                funit_o    = FUNIT_ALU;
                alu_op_o   = arith_op;
                src1_sel_o = SRC1_SEL_RS1;
                src2_sel_o = (opcode == OPC_OP) ? SRC2_SEL_RS2 : SRC2_SEL_IMM;
                rd_sel_o   = RD_SEL_FUNIT;
            end
            default: ;
        endcase
    end

endmodule

/* secv_gpr.sv */
// SEC-V register file
`timescale 1ns/1ps

module secv_gpr (
    input  logic               clk_i,
    input  logic               rst_i,
    input  secv_pkg::reg_adr_t rs1_adr_i,
    input  secv_pkg::reg_adr_t rs2_adr_i,
    input  secv_pkg::reg_adr_t rd_adr_i,
    output secv_pkg::word_t    rs1_dat_o,
    output secv_pkg::word_t    rs2_dat_o,
    input  secv_pkg::word_t    rd_dat_i,
    input  logic               rd_wb_i
);
    import secv_pkg::*;

    // Storage for x1 to x31 only
    word_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wb_i && rd_adr_i != '0) begin
            regs[rd_adr_i] <= rd_dat_i;
        end
    end

    // Asynchronous reads
    assign rs1_dat_o = (rs1_adr_i == '0) ? '0 : regs[rs1_adr_i];
    assign rs2_dat_o = (rs2_adr_i == '0) ? '0 : regs[rs2_adr_i];

endmodule

/* secv_lsu.sv */
// SEC-V load/store unit
`timescale 1ns/1ps

module secv_lsu (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            ena_i,
    input  logic            we_i,
    input  secv_pkg::word_t adr_i,
    input  secv_pkg::word_t wdat_i,
    output secv_pkg::word_t rdat_o,
    output logic            rdy_o,
    output logic            dmem_cyc_o,
    output logic            dmem_stb_o,
    output logic            dmem_we_o,
    output secv_pkg::sel_t  dmem_sel_o,
    output secv_pkg::dadr_t dmem_adr_o,
    output secv_pkg::word_t dmem_dat_o,
    input  secv_pkg::word_t dmem_dat_i,
    input  logic            dmem_ack_i
);
    import secv_pkg::*;

    logic done;
    logic req;

    // One access per enable until acked
    assign req        = ena_i && !done;
    assign dmem_cyc_o = req;
    assign dmem_stb_o = req;
    assign dmem_we_o  = req && we_i;
    assign dmem_sel_o = '1;
    assign dmem_adr_o = adr_i[DADR_WIDTH-1:0];
    assign dmem_dat_o = wdat_i;
    assign rdy_o      = done;

    // Done holds until the controller drops enable
    always_ff @(posedge clk_i) begin
        if (rst_i || !ena_i) begin
            done <= 1'b0;
        end else if (req && dmem_ack_i) begin
            done <= 1'b1;
        end
    end

    // Load data capture
    always_ff @(posedge clk_i) begin
        if (req && dmem_ack_i && !we_i) begin
            rdat_o <= dmem_dat_i;
        end
    end

    // Bus cycle ends right after ack
    a_ack_end: assert property (@(posedge clk_i) disable iff (rst_i)
        (dmem_stb_o && dmem_ack_i) |=> !dmem_cyc_o);

    // Request and address held until ack
    a_stb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (dmem_stb_o && !dmem_ack_i) |=> (dmem_stb_o && $stable(dmem_adr_o)));

endmodule

/* secv_pkg.sv */
// SEC-V shared definitions
package secv_pkg;

    // Datapath and bus widths
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int IADR_WIDTH = 12;
    localparam int DADR_WIDTH = 12;
    localparam int SEL_WIDTH  = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [4:0]            reg_adr_t;
    typedef logic [IADR_WIDTH-1:0] iadr_t;
    typedef logic [DADR_WIDTH-1:0] dadr_t;
    typedef logic [SEL_WIDTH-1:0]  sel_t;
    typedef logic [2:0]            funct3_t;

    // Main FSM states for one instruction at a time
    typedef enum logic [2:0] {
        STATE_IDLE, STATE_FETCH, STATE_DECODE, STATE_EXECUTE, STATE_WB
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // Unit that produces the result of an instruction
    typedef enum logic [1:0] {FUNIT_NONE, FUNIT_ALU, FUNIT_MEM} funit_t;

    typedef enum logic [1:0] {SRC1_SEL_ZERO, SRC1_SEL_RS1, SRC1_SEL_PC} src1_sel_t;
    typedef enum logic [1:0] {SRC2_SEL_ZERO, SRC2_SEL_RS2, SRC2_SEL_IMM} src2_sel_t;

    // Destination register source
    typedef enum logic [1:0] {
        RD_SEL_NONE, RD_SEL_FUNIT, RD_SEL_IMM, RD_SEL_NXTPC
    } rd_sel_t;

    // Next PC source
    typedef enum logic [1:0] {PC_SEL_NXTPC, PC_SEL_FUNIT, PC_SEL_BRANCH} pc_sel_t;

    // RV32I base opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // addi x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;

endpackage

/* tb_secv_model.svh */
// SEC-V reference model
`ifndef TB_SECV_MODEL_SVH
`define TB_SECV_MODEL_SVH

// Random source state
logic [31:0] lfsr = 32'd80;

// Architectural state of the model
word_t m_pc = '0;
word_t m_regs [32] = '{default: '0};
int    m_n_load  = 0;
int    m_n_store = 0;

// Expected data bus accesses in issue order
logic  q_we  [$];
word_t q_adr [$];
word_t q_dat [$];
int    q_dly [$];

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// Integer result for OP and OP-IMM
function automatic word_t alu_ref(input funct3_t f3, input logic alt,
                                  input word_t a, input word_t b);
    word_t r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_ref(input funct3_t f3, input word_t a, input word_t b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// Builds one random instruction and retires it in the model
function automatic inst_t next_inst();
    logic [31:0] t;
    logic [19:0] r;
    logic [3:0]  kind;
    reg_adr_t    rd;
    reg_adr_t    rs1;
    reg_adr_t    rs2;
    funct3_t     f3;
    logic        alt;
    logic        wr;
    logic [1:0]  dly;
    logic [11:0] imm12;
    logic [12:0] off13;
    logic [20:0] off21;
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       nxt;
    inst_t       inst;
    t = rand_bits(25);
    {kind, rd, rs1, rs2, f3, alt, dly} = t[24:0];
    t = rand_bits(20);
    r = t[19:0];
    a = m_regs[rs1];
    b = m_regs[rs2];
    imm12 = r[11:0];
    // Link value and fall-through PC
    res = m_pc + 32'd4;
    nxt = m_pc + 32'd4;
    wr  = 1'b1;
    case (kind)
        4'd0, 4'd1, 4'd2: begin
            alt  = alt & (f3 == 3'd0 || f3 == 3'd5);
            inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
            res  = alu_ref(f3, alt, a, b);
        end
        4'd3, 4'd4, 4'd5: begin
            alt = alt & (f3 == 3'd5);
            // Shifts carry a 5-bit amount
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm12 = {1'b0, alt, 5'b0, r[4:0]};
            end
            inst = {imm12, rs1, f3, rd, OPC_OPIMM};
            res  = alu_ref(f3, alt, a, sext12(imm12));
        end
        4'd6: begin
            inst = {r, rd, OPC_LUI};
            res  = {r, 12'b0};
        end
        4'd7: begin
            inst = {r, rd, OPC_AUIPC};
            res  = m_pc + {r, 12'b0};
        end
        4'd8, 4'd9: begin
            inst = {imm12, rs1, 3'b010, rd, OPC_LOAD};
            t    = rand_bits(32);
            res  = t;
            q_we.push_back(1'b0);
            q_adr.push_back(a + sext12(imm12));
            q_dat.push_back(res);
            q_dly.push_back(int'(dly));
            m_n_load++;
        end
        4'd10, 4'd11: begin
            inst = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OPC_STORE};
            wr   = 1'b0;
            q_we.push_back(1'b1);
            q_adr.push_back(a + sext12(imm12));
            q_dat.push_back(b);
            q_dly.push_back(int'(dly));
            m_n_store++;
        end
        4'd12, 4'd13: begin
            wr = 1'b0;
            // Funct3 2 and 3 are not branches
            if (f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;
            end
            off13 = {r[11:1], 2'b00};
            inst  = {off13[12], off13[10:5], rs2, rs1, f3, off13[4:1], off13[11], OPC_BRANCH};
            if (branch_ref(f3, a, b)) begin
                nxt = m_pc + {{19{off13[12]}}, off13};
            end
        end
        4'd14: begin
            off21 = {r[19:1], 2'b00};
            inst  = {off21[20], off21[10:1], off21[11], off21[19:12], rd, OPC_JAL};
            nxt   = m_pc + {{11{off21[20]}}, off21};
        end
        default: begin
            // Low immediate bits cancel those of rs1
            imm12 = {r[11:2], 2'b00 - a[1:0]};
            inst  = {imm12, rs1, 3'b000, rd, OPC_JALR};
            nxt   = (a + sext12(imm12)) & ~32'd1;
        end
    endcase
    if (wr && rd != 5'd0) begin
        m_regs[rd] = res;
    end
    m_pc = nxt;
    return inst;
endfunction

`endif

/* tb_secv.sv */
// SEC-V core testbench
`timescale 1ns/1ps

module tb_secv;
    import secv_pkg::*;

    localparam int N_INST   = 400;
    localparam int MAX_WAIT = 20000;

    logic  clk_i;
    logic  rst_i;
    logic  imem_cyc_o;
    logic  imem_stb_o;
    sel_t  imem_sel_o;
    iadr_t imem_adr_o;
    inst_t imem_dat_i;
    logic  imem_ack_i;
    logic  dmem_cyc_o;
    logic  dmem_stb_o;
    logic  dmem_we_o;
    sel_t  dmem_sel_o;
    dadr_t dmem_adr_o;
    word_t dmem_dat_o;
    word_t dmem_dat_i;
    logic  dmem_ack_i;

    // Per-test counters
    int   n_fetch;
    int   err_fetch;
    int   n_load;
    int   n_store;
    int   err_mem;
    int   err_reset;
    int   err_run;
    logic fetch_done;

    `include "tb_secv_model.svh"

    secv u_secv (
        .clk_i      (clk_i),      .rst_i      (rst_i),
        .imem_cyc_o (imem_cyc_o), .imem_stb_o (imem_stb_o),
        .imem_sel_o (imem_sel_o), .imem_adr_o (imem_adr_o),
        .imem_dat_i (imem_dat_i), .imem_ack_i (imem_ack_i),
        .dmem_cyc_o (dmem_cyc_o), .dmem_stb_o (dmem_stb_o),
        .dmem_we_o  (dmem_we_o),  .dmem_sel_o (dmem_sel_o),
        .dmem_adr_o (dmem_adr_o), .dmem_dat_o (dmem_dat_o),
        .dmem_dat_i (dmem_dat_i), .dmem_ack_i (dmem_ack_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Instruction memory with a fresh instruction per fetch
    initial begin : imem_responder
        logic [31:0] t;
        int          wait_cyc;
        logic        busy;
        imem_ack_i = 1'b0;
        imem_dat_i = INST_NOP;
        n_fetch    = 0;
        err_fetch  = 0;
        fetch_done = 1'b0;
        busy       = 1'b0;
        wait_cyc   = 0;
        forever begin
            @(negedge clk_i);
            imem_ack_i = 1'b0;
            if (imem_stb_o === 1'b1 && !busy && !fetch_done) begin
                if (imem_cyc_o !== 1'b1 || imem_sel_o !== 4'hf) begin
                    $display("fetch at %0t without cyc or with a partial byte select", $time);
                    err_fetch++;
                end
                if (imem_adr_o !== m_pc[IADR_WIDTH-1:0]) begin
                    $display("mismatch at %0t: imem_adr_o got %h expected %h",
                             $time, imem_adr_o, m_pc[IADR_WIDTH-1:0]);
                    err_fetch++;
                end
                // Request after the last instruction is left hanging
                if (n_fetch == N_INST) begin
                    fetch_done = 1'b1;
                end else begin
                    imem_dat_i = next_inst();
                    n_fetch++;
                    busy     = 1'b1;
                    t        = rand_bits(2);
                    wait_cyc = int'(t[1:0]);
                end
            end else if (busy && imem_stb_o !== 1'b1) begin
                $display("fetch request dropped before ack at %0t", $time);
                err_fetch++;
                busy = 1'b0;
            end
            if (busy) begin
                if (wait_cyc == 0) begin
                    imem_ack_i = 1'b1;
                    busy = 1'b0;
                end else begin
                    wait_cyc--;
                end
            end
        end
    end

    // Data memory checking each access against the model queue
    initial begin : dmem_responder
        int    wait_cyc;
        logic  busy;
        logic  exp_we;
        word_t exp_adr;
        word_t exp_dat;
        dmem_ack_i = 1'b0;
        dmem_dat_i = '0;
        n_load     = 0;
        n_store    = 0;
        err_mem    = 0;
        busy       = 1'b0;
        wait_cyc   = 0;
        forever begin
            @(negedge clk_i);
            dmem_ack_i = 1'b0;
            if (dmem_stb_o === 1'b1 && !busy) begin
                busy     = 1'b1;
                wait_cyc = 0;
                // Accesses counted as the DUT issues them
                if (dmem_we_o === 1'b1) begin
                    n_store++;
                end else begin
                    n_load++;
                end
                if (dmem_cyc_o !== 1'b1 || dmem_sel_o !== 4'hf) begin
                    $display("data access at %0t without cyc or with a partial byte select",
                             $time);
                    err_mem++;
                end
                if (q_we.size() == 0) begin
                    $display("data access at %0t with no load or store pending", $time);
                    err_mem++;
                end else begin
                    exp_we   = q_we.pop_front();
                    exp_adr  = q_adr.pop_front();
                    exp_dat  = q_dat.pop_front();
                    wait_cyc = q_dly.pop_front();
                    if (dmem_we_o !== exp_we) begin
                        $display("mismatch at %0t: dmem_we_o got %b expected %b",
                                 $time, dmem_we_o, exp_we);
                        err_mem++;
                    end
                    if (dmem_adr_o !== exp_adr[DADR_WIDTH-1:0]) begin
                        $display("mismatch at %0t: dmem_adr_o got %h expected %h",
                                 $time, dmem_adr_o, exp_adr[DADR_WIDTH-1:0]);
                        err_mem++;
                    end
                    if (exp_we && dmem_dat_o !== exp_dat) begin
                        $display("mismatch at %0t: dmem_dat_o got %h expected %h",
                                 $time, dmem_dat_o, exp_dat);
                        err_mem++;
                    end
                    // Load data was chosen by the model
                    dmem_dat_i = exp_dat;
                end
            end else if (busy && dmem_stb_o !== 1'b1) begin
                $display("data request dropped before ack at %0t", $time);
                err_mem++;
                busy = 1'b0;
            end
            if (busy) begin
                if (wait_cyc == 0) begin
                    dmem_ack_i = 1'b1;
                    busy = 1'b0;
                end else begin
                    wait_cyc--;
                end
            end
        end
    end

    initial begin : main
        int cycles;
        int total;
        rst_i     = 1'b1;
        err_reset = 0;
        err_run   = 0;
        // Buses idle through reset and the IDLE cycle
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            if (imem_cyc_o !== 1'b0 || dmem_cyc_o !== 1'b0) begin
                $display("bus cycle active during reset at %0t", $time);
                err_reset++;
            end
        end
        rst_i  = 1'b0;
        cycles = 0;
        while (imem_stb_o !== 1'b1 && cycles < 10) begin
            @(negedge clk_i);
            cycles++;
        end
        if (imem_stb_o !== 1'b1) begin
            $display("no fetch within 10 cycles after reset");
            err_reset++;
        end else if (cycles != 1) begin
            $display("first fetch came %0d cycles after reset instead of 1", cycles);
            err_reset++;
        end else if (imem_adr_o !== '0) begin
            $display("mismatch at %0t: imem_adr_o got %h expected 000", $time, imem_adr_o);
            err_reset++;
        end
        $display("test reset: %0d errors", err_reset);

        // Random program until the model has retired every instruction
        cycles = 0;
        while (!fetch_done && cycles < MAX_WAIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!fetch_done) begin
            $display("timeout after %0d cycles with %0d of %0d instructions fetched",
                     cycles, n_fetch, N_INST);
            err_run++;
        end
        if (q_we.size() != 0 || n_load != m_n_load || n_store != m_n_store) begin
            $display("data bus saw %0d loads and %0d stores, the program had %0d and %0d",
                     n_load, n_store, m_n_load, m_n_store);
            err_run++;
        end
        $display("test fetch: %0d instructions, %0d errors", n_fetch, err_fetch);
        $display("test data bus: %0d loads, %0d stores, %0d errors", n_load, n_store, err_mem);
        $display("test access count: %0d errors", err_run);
        total = err_reset + err_fetch + err_mem + err_run;
        $display("summary: 4 tests, %0d instructions, %0d errors", n_fetch, total);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
